// File: rtl/blit_pkg.sv
package blit_pkg;

    localparam int word_width        = 32;
    localparam int coord_width       = 16;
    localparam int addr_width        = 26;
    localparam int color_width       = 8;
    localparam int transparent_width = color_width + 1;
    localparam int fifo_depth        = 16;

    // Bit 8 set means no color is treated as transparent
    localparam logic [transparent_width-1:0] transparent_off = 9'h100;

    // Parameter words that follow each multi-word command
    localparam logic [2:0] rect_args  = 3'd2;  // Corner 1, corner 2
    localparam logic [2:0] copy_args  = 3'd3;  // Corner 1, corner 2, source point
    localparam logic [2:0] setup_args = 3'd6;

    // Opcode lives in the top byte of the command word, bit 7 marks privileged
    typedef enum logic [7:0] {
        opc_nop              = 8'h00,
        opc_draw_rect        = 8'h01,
        opc_copy_rect        = 8'h02,
        opc_set_transparency = 8'h04,
        opc_setup            = 8'hff
    } blit_opcode_t;

    typedef enum logic [1:0] {
        op_rect_fill = 2'd0,
        op_rect_copy = 2'd1
    } blit_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_rect,       // Collecting DRAW_RECT corners
        st_copy,       // Collecting COPY_RECT corners and source point
        st_setup,
        st_wait_ack,
        st_wait_busy
    } decoder_state_t;

    typedef enum logic [2:0] {
        fld_dest_stride,
        fld_dest_addr,
        fld_clip_min,
        fld_clip_max,
        fld_offset,
        fld_src_addr,
        fld_src_stride,
        fld_transparent
    } cfg_field_t;

endpackage

// File: rtl/blit_cmd_fifo.sv
`timescale 1ns/1ps

module blit_cmd_fifo
    import blit_pkg::*;
#(
    parameter int depth = fifo_depth
) (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  cmd_valid,
    input  logic                  cmd_privileged,
    input  logic [word_width-1:0] cmd_word,
    output logic                  cmd_ready,

    output logic                  head_valid,
    output logic                  head_privileged,
    output logic [word_width-1:0] head_word,
    input  logic                  pop
);

    localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    logic [word_width:0]    mem [depth];  // Privilege bit stored above the word
    logic [ptr_width-1:0]   rd_ptr;
    logic [ptr_width-1:0]   wr_ptr;
    logic [count_width-1:0] count;
    logic                   push;
    logic                   do_pop;

    // Wrap explicitly so a depth that is not a power of two still works
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(depth - 1)) begin
            return '0;
        end
        return ptr + ptr_width'(1);
    endfunction

    assign cmd_ready  = (count != count_width'(depth));
    assign head_valid = (count != '0);
    assign push       = cmd_valid && cmd_ready;
    assign do_pop     = pop && head_valid;

    assign {head_privileged, head_word} = mem[rd_ptr];  // Show-ahead head entry

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= {cmd_privileged, cmd_word};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, do_pop})
                2'b10:   count <= count + count_width'(1);
                2'b01:   count <= count - count_width'(1);
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

endmodule

// File: rtl/blit_setup_regs.sv
`timescale 1ns/1ps

module blit_setup_regs
    import blit_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,

    input  logic                         cfg_write,
    input  cfg_field_t                   cfg_field,
    input  logic [word_width-1:0]        cfg_data,

    output logic [coord_width-1:0]       offset_x,
    output logic [coord_width-1:0]       offset_y,
    output logic [coord_width-1:0]       clip_x1,
    output logic [coord_width-1:0]       clip_y1,
    output logic [coord_width-1:0]       clip_x2,
    output logic [coord_width-1:0]       clip_y2,
    output logic [coord_width-1:0]       dest_stride,
    output logic [coord_width-1:0]       src_stride,
    output logic [addr_width-1:0]        dest_base_addr,
    output logic [addr_width-1:0]        src_base_addr,
    output logic [transparent_width-1:0] transparent_color
);

    logic [coord_width-1:0] data_lo;
    logic [coord_width-1:0] data_hi;

    // Coordinate pairs carry x in the low half, y in the high half
    assign data_lo = cfg_data[coord_width-1:0];
    assign data_hi = cfg_data[2*coord_width-1:coord_width];

    always_ff @(posedge clock) begin
        if (reset) begin
            offset_x          <= '0;
            offset_y          <= '0;
            clip_x1           <= '0;
            clip_y1           <= '0;
            clip_x2           <= '0;
            clip_y2           <= '0;
            dest_stride       <= '0;
            src_stride        <= '0;
            dest_base_addr    <= '0;
            src_base_addr     <= '0;
            transparent_color <= transparent_off;
        end else if (cfg_write) begin
            case (cfg_field)
                fld_dest_stride: dest_stride <= data_lo;
                fld_dest_addr:   dest_base_addr <= cfg_data[addr_width-1:0];
                fld_clip_min: begin
                    clip_x1 <= data_lo;
                    clip_y1 <= data_hi;
                end
                fld_clip_max: begin
                    clip_x2 <= data_lo;
                    clip_y2 <= data_hi;
                end
                fld_offset: begin
                    offset_x <= data_lo;  // Added to every later coordinate
                    offset_y <= data_hi;
                end
                fld_src_addr:    src_base_addr <= cfg_data[addr_width-1:0];
                fld_src_stride:  src_stride <= data_lo;
                fld_transparent: transparent_color <= cfg_data[transparent_width-1:0];
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/blit_cmd_decoder.sv
`timescale 1ns/1ps

module blit_cmd_decoder
    import blit_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,

    // Show-ahead FIFO head
    input  logic                   head_valid,
    input  logic                   head_privileged,
    input  logic [word_width-1:0]  head_word,
    output logic                   pop,

    // Configuration writes
    output logic                   cfg_write,
    output cfg_field_t             cfg_field,
    output logic [word_width-1:0]  cfg_data,
    input  logic [coord_width-1:0] offset_x,
    input  logic [coord_width-1:0] offset_y,

    // Blitter core
    output logic                   start,
    output blit_op_t               blit_op,
    output logic [coord_width-1:0] x1,
    output logic [coord_width-1:0] y1,
    output logic [coord_width-1:0] x2,
    output logic [coord_width-1:0] y2,
    output logic [coord_width-1:0] src_x,
    output logic [coord_width-1:0] src_y,
    output logic [color_width-1:0] color,
    input  logic                   ack,
    input  logic                   busy
);

    decoder_state_t         state;
    logic [2:0]             arg_count;
    blit_opcode_t           opcode;
    logic                   allowed;
    logic [coord_width-1:0] point_x;
    logic [coord_width-1:0] point_y;

    assign opcode  = blit_opcode_t'(head_word[word_width-1:word_width-8]);
    assign allowed = !head_word[word_width-1] || head_privileged;  // Bit 7 needs privilege

    // Parameter word as a point, shifted by the drawing offset, wraps at 16 bits
    assign point_x = head_word[coord_width-1:0] + offset_x;
    assign point_y = head_word[2*coord_width-1:coord_width] + offset_y;

    assign cfg_data = head_word;

    // Pop and config writes follow the head directly
    always_comb begin
        pop       = 1'b0;
        cfg_write = 1'b0;
        cfg_field = fld_dest_stride;
        case (state)
            st_idle: begin
                pop = head_valid;  // Every command word is consumed, even if ignored
                if (head_valid && allowed) begin
                    if (opcode == opc_setup) begin
                        cfg_write = 1'b1;
                        cfg_field = fld_dest_stride;
                    end else if (opcode == opc_set_transparency) begin
                        cfg_write = 1'b1;
                        cfg_field = fld_transparent;
                    end
                end
            end
            st_rect, st_copy: pop = head_valid;
            st_setup: begin
                pop       = head_valid;
                cfg_write = head_valid;
                case (arg_count)
                    3'd0:    cfg_field = fld_dest_addr;
                    3'd1:    cfg_field = fld_clip_min;
                    3'd2:    cfg_field = fld_clip_max;
                    3'd3:    cfg_field = fld_offset;
                    3'd4:    cfg_field = fld_src_addr;
                    default: cfg_field = fld_src_stride;
                endcase
            end
            default: ;  // No popping while the core owns the operands
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= st_idle;
            arg_count <= '0;
            start     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    arg_count <= '0;
                    if (head_valid && allowed) begin
                        case (opcode)
                            opc_draw_rect: state <= st_rect;
                            opc_copy_rect: state <= st_copy;
                            opc_setup:     state <= st_setup;
                            default: ;  // NOP, SET_TRANSPARENCY and unknown codes
                        endcase
                    end
                end
                st_rect: begin
                    if (head_valid) begin
                        arg_count <= arg_count + 3'd1;
                        if (arg_count == rect_args - 3'd1) begin
                            start <= 1'b1;
                            state <= st_wait_ack;
                        end
                    end
                end
                st_copy: begin
                    if (head_valid) begin
                        arg_count <= arg_count + 3'd1;
                        if (arg_count == copy_args - 3'd1) begin
                            start <= 1'b1;
                            state <= st_wait_ack;
                        end
                    end
                end
                st_setup: begin
                    if (head_valid) begin
                        arg_count <= arg_count + 3'd1;
                        if (arg_count == setup_args - 3'd1) begin
                            state <= st_idle;
                        end
                    end
                end
                st_wait_ack: begin
                    if (ack) begin
                        start <= 1'b0;
                        state <= st_wait_busy;
                    end
                end
                st_wait_busy: begin
                    if (!busy) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Operand registers, held from start until the return to idle
    always_ff @(posedge clock) begin
        if (state == st_idle && head_valid && allowed &&
                (opcode == opc_draw_rect || opcode == opc_copy_rect)) begin
            color <= head_word[color_width-1:0];
        end
        if ((state == st_rect || state == st_copy) && head_valid) begin
            case (arg_count)
                3'd0: begin
                    x1 <= point_x;
                    y1 <= point_y;
                end
                3'd1: begin
                    x2 <= point_x;
                    y2 <= point_y;
                end
                default: begin
                    src_x <= point_x;  // Only reached by COPY_RECT
                    src_y <= point_y;
                end
            endcase
            blit_op <= (state == st_copy) ? op_rect_copy : op_rect_fill;
        end
    end

endmodule

// File: rtl/blit_command_parser.sv
`timescale 1ns/1ps

module blit_command_parser
    import blit_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,

    // CPU write side
    input  logic                         cmd_valid,
    input  logic [word_width-1:0]        cmd_word,
    input  logic                         cmd_privileged,
    output logic                         cmd_ready,

    // Operation to the blitter core
    output logic                         start,
    output blit_op_t                     blit_op,
    output logic [coord_width-1:0]       x1,
    output logic [coord_width-1:0]       y1,
    output logic [coord_width-1:0]       x2,  // Exclusive upper bounds
    output logic [coord_width-1:0]       y2,
    output logic [coord_width-1:0]       src_x,
    output logic [coord_width-1:0]       src_y,
    output logic [color_width-1:0]       color,

    // Persistent configuration
    output logic [coord_width-1:0]       clip_x1,
    output logic [coord_width-1:0]       clip_y1,
    output logic [coord_width-1:0]       clip_x2,
    output logic [coord_width-1:0]       clip_y2,
    output logic [addr_width-1:0]        dest_base_addr,
    output logic [coord_width-1:0]       dest_stride,
    output logic [addr_width-1:0]        src_base_addr,
    output logic [coord_width-1:0]       src_stride,
    output logic [transparent_width-1:0] transparent_color,

    input  logic                         ack,
    input  logic                         busy
);

    logic                   head_valid;
    logic                   head_privileged;
    logic [word_width-1:0]  head_word;
    logic                   pop;
    logic                   cfg_write;
    cfg_field_t             cfg_field;
    logic [word_width-1:0]  cfg_data;
    logic [coord_width-1:0] offset_x;
    logic [coord_width-1:0] offset_y;

    blit_cmd_fifo #(
        .depth(fifo_depth)
    ) fifo_i (
        .clock,
        .reset,
        .cmd_valid,
        .cmd_privileged,
        .cmd_word,
        .cmd_ready,
        .head_valid,
        .head_privileged,
        .head_word,
        .pop
    );

    blit_cmd_decoder decoder_i (
        .clock,
        .reset,
        .head_valid,
        .head_privileged,
        .head_word,
        .pop,
        .cfg_write,
        .cfg_field,
        .cfg_data,
        .offset_x,
        .offset_y,
        .start,
        .blit_op,
        .x1,
        .y1,
        .x2,
        .y2,
        .src_x,
        .src_y,
        .color,
        .ack,
        .busy
    );

    blit_setup_regs regs_i (
        .clock,
        .reset,
        .cfg_write,
        .cfg_field,
        .cfg_data,
        .offset_x,
        .offset_y,
        .clip_x1,
        .clip_y1,
        .clip_x2,
        .clip_y2,
        .dest_stride,
        .src_stride,
        .dest_base_addr,
        .src_base_addr,
        .transparent_color
    );

endmodule

// File: verif/blit_command_parser_asserts.sv
`timescale 1ns/1ps

module blit_command_parser_asserts
    import blit_pkg::*;
(
    input logic                   clock,
    input logic                   reset,
    input logic                   cmd_valid,
    input logic                   cmd_ready,
    input logic                   pop,
    input logic                   head_valid,
    input logic                   start,
    input logic                   ack,
    input logic [1:0]             blit_op,
    input logic [coord_width-1:0] x1,
    input logic [coord_width-1:0] y1,
    input logic [coord_width-1:0] x2,
    input logic [coord_width-1:0] y2,
    input logic [coord_width-1:0] src_x,
    input logic [coord_width-1:0] src_y,
    input logic [color_width-1:0] color
);

    logic [2+6*coord_width+color_width-1:0] operands;

    assign operands = {blit_op, x1, y1, x2, y2, src_x, src_y, color};

    start_until_ack: assert property (@(posedge clock) disable iff (reset)
        start && !ack |=> start)
        else $error("start dropped before ack");

    operands_stable: assert property (@(posedge clock) disable iff (reset)
        start && !ack |=> $stable(operands))
        else $error("operands changed while start was high");

    pop_needs_head: assert property (@(posedge clock) disable iff (reset)
        pop |-> head_valid)
        else $error("pop with empty FIFO");

    // Full FIFO that pops nothing must refuse the offered word
    no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        cmd_valid && !cmd_ready && !pop |=> !cmd_ready)
        else $error("write accepted while cmd_ready was low");

endmodule

bind blit_command_parser blit_command_parser_asserts asserts_i (
    .clock      (clock),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .pop        (pop),
    .head_valid (head_valid),
    .start      (start),
    .ack        (ack),
    .blit_op    (blit_op),
    .x1         (x1),
    .y1         (y1),
    .x2         (x2),
    .y2         (y2),
    .src_x      (src_x),
    .src_y      (src_y),
    .color      (color)
);

// File: verif/blit_command_parser_tb.sv
`timescale 1ns/1ps

module blit_command_parser_tb
    import blit_pkg::*;
();

    typedef logic [2+6*coord_width+color_width-1:0] operation_t;  // op, 6 coords, color

    logic                         clock;
    logic                         reset;
    logic                         cmd_valid;
    logic [word_width-1:0]        cmd_word;
    logic                         cmd_privileged;
    logic                         cmd_ready;
    logic                         start;
    blit_op_t                     blit_op;
    logic [coord_width-1:0]       x1, y1, x2, y2, src_x, src_y;
    logic [color_width-1:0]       color;
    logic [coord_width-1:0]       clip_x1, clip_y1, clip_x2, clip_y2;
    logic [coord_width-1:0]       dest_stride, src_stride;
    logic [addr_width-1:0]        dest_base_addr, src_base_addr;
    logic [transparent_width-1:0] transparent_color;
    logic                         ack;
    logic                         busy;

    int          seed;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          test_errors;
    int          total_words = 0;
    int          cycle_count = 0;
    int          full_cycles = 0;
    int          full_before;
    int          pick;
    int          ack_span;   // Ack delay is 0 .. ack_span-1 cycles
    int          busy_span;  // Busy lasts 1 .. busy_span cycles
    string       test_name;
    logic [31:0] words[$];
    logic        privs[$];
    operation_t  exp_q[$];

    // Reference decoder state is 0 idle, 1 rect corners, 2 copy points, 3 setup words
    int                           m_state;
    int                           m_args;
    logic [color_width-1:0]       m_color;
    logic [31:0]                  m_pts[3];  // {y, x} with offset applied
    logic [coord_width-1:0]       sh_off_x, sh_off_y;
    logic [coord_width-1:0]       sh_clip_x1, sh_clip_y1, sh_clip_x2, sh_clip_y2;
    logic [coord_width-1:0]       sh_dest_stride, sh_src_stride;
    logic [addr_width-1:0]        sh_dest_addr, sh_src_addr;
    logic [transparent_width-1:0] sh_transp;

    blit_command_parser dut_i (.*);

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (!cmd_ready) begin
            full_cycles <= full_cycles + 1;
        end
        if (cycle_count > 40 * total_words + 200) begin
            $display("Timeout after %0d cycles in %s, DUT stopped making progress",
                     cycle_count, test_name);
            $display("sim failed");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_config();
        check_value("clip_x1", sh_clip_x1, clip_x1);
        check_value("clip_y1", sh_clip_y1, clip_y1);
        check_value("clip_x2", sh_clip_x2, clip_x2);
        check_value("clip_y2", sh_clip_y2, clip_y2);
        check_value("dest_base_addr", sh_dest_addr, dest_base_addr);
        check_value("dest_stride", sh_dest_stride, dest_stride);
        check_value("src_base_addr", sh_src_addr, src_base_addr);
        check_value("src_stride", sh_src_stride, src_stride);
        check_value("transparent_color", sh_transp, transparent_color);
    endtask

    task automatic add_word(input logic [31:0] w, input logic priv);
        words.push_back(w);
        privs.push_back(priv);
    endtask

    task automatic add_params(input int n);
        repeat (n) begin
            add_word($random(seed), rand_below(2) == 1);
        end
    endtask

    // Command kinds 0 NOP, 1 DRAW_RECT, 2 COPY_RECT, 3 SET_TRANSPARENCY, 4 SETUP, 5 unknown
    task automatic add_command(input int kind, input logic priv);
        logic [31:0] r;
        r = $random(seed);
        case (kind)
            0: add_word({opc_nop, r[23:0]}, priv);
            1: begin
                add_word({opc_draw_rect, r[23:0]}, priv);
                add_params(2);
            end
            2: begin
                add_word({opc_copy_rect, r[23:0]}, priv);
                add_params(3);
            end
            3: add_word({opc_set_transparency, r[23:0]}, priv);
            4: begin
                add_word({opc_setup, r[23:0]}, priv);
                if (priv) begin
                    add_params(6);  // Without privilege the next commands follow directly
                end
            end
            default: begin
                if (r[31]) begin
                    add_word({1'b1, 7'(rand_below(127)), r[23:0]}, priv);  // 80 .. FE
                end else begin
                    add_word({8'h08 + 8'(rand_below(112)), r[23:0]}, priv);  // 08 .. 77
                end
            end
        endcase
    endtask

    task automatic model_word(input logic [31:0] w, input logic priv);
        logic [31:0] pt;
        blit_op_t    op;
        pt = {w[31:16] + sh_off_y, w[15:0] + sh_off_x};  // Each half wraps at 16 bits
        case (m_state)
            1, 2: begin
                m_pts[m_args] = pt;
                m_args++;
                if (m_args == m_state + 1) begin  // Rect needs 2 words, copy needs 3
                    op = (m_state == 2) ? op_rect_copy : op_rect_fill;
                    if (m_state == 1) begin
                        m_pts[2] = '0;
                    end
                    exp_q.push_back({op, m_pts[0][15:0], m_pts[0][31:16], m_pts[1][15:0],
                                     m_pts[1][31:16], m_pts[2][15:0], m_pts[2][31:16], m_color});
                    m_state = 0;
                end
            end
            3: begin
                case (m_args)
                    0: sh_dest_addr = w[addr_width-1:0];
                    1: {sh_clip_y1, sh_clip_x1} = w;
                    2: {sh_clip_y2, sh_clip_x2} = w;
                    3: {sh_off_y, sh_off_x} = w;
                    4: sh_src_addr = w[addr_width-1:0];
                    default: sh_src_stride = w[15:0];
                endcase
                m_args++;
                if (m_args == 6) begin
                    m_state = 0;
                end
            end
            default: begin
                m_args = 0;
                if (!w[31] || priv) begin  // Privileged opcodes without privilege are dropped
                    case (w[31:24])
                        opc_draw_rect, opc_copy_rect: begin
                            m_state = (w[31:24] == opc_copy_rect) ? 2 : 1;
                            m_color = w[7:0];
                        end
                        opc_set_transparency: sh_transp = w[8:0];
                        opc_setup: begin
                            m_state = 3;
                            sh_dest_stride = w[15:0];
                        end
                        default: ;
                    endcase
                end
            end
        endcase
    endtask

    task automatic push_list();
        int   idx;
        logic taken;
        idx = 0;
        while (idx < words.size()) begin
            @(negedge clock);
            taken = cmd_valid && cmd_ready;
            @(posedge clock);
            if (taken) begin
                idx++;
            end
            if (!cmd_valid || taken) begin  // A pending word stays until accepted
                if (idx < words.size() && rand_below(4) != 0) begin
                    cmd_valid      <= 1'b1;
                    cmd_word       <= words[idx];
                    cmd_privileged <= privs[idx];
                end else begin
                    cmd_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic run_test();
        foreach (words[i]) begin
            model_word(words[i], privs[i]);
        end
        total_words += words.size();
        push_list();
        words.delete();
        privs.delete();
        @(negedge clock);
        while (exp_q.size() != 0 || dut_i.head_valid || start || busy) begin
            @(negedge clock);
        end
        check_config();
        tests_run++;
        $display("test %s finished with %0d errors", test_name, errors - test_errors);
    endtask

    // Blitter core model that checks operands while start waits for ack
    initial begin : core_responder
        int         wait_cycles;
        operation_t actual;
        forever begin
            @(negedge clock);
            if (start) begin
                wait_cycles = rand_below(ack_span);
                repeat (wait_cycles) @(negedge clock);
                actual = {blit_op, x1, y1, x2, y2,
                          (blit_op == op_rect_copy) ? {src_x, src_y} : 32'h0, color};
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: start raised with no operation expected", test_name);
                end else begin
                    check_value("operation", exp_q[0], actual);
                    void'(exp_q.pop_front());
                end
                @(posedge clock);
                ack  <= 1'b1;
                busy <= 1'b1;
                @(posedge clock);
                ack <= 1'b0;
                repeat (rand_below(busy_span)) @(posedge clock);
                busy <= 1'b0;
            end
        end
    end

    initial begin
        seed           = 32'h5790_ebfb;
        clock          = 1'b0;
        reset          = 1'b1;
        cmd_valid      = 1'b0;
        cmd_word       = '0;
        cmd_privileged = 1'b0;
        ack            = 1'b0;
        busy           = 1'b0;
        ack_span       = 4;
        busy_span      = 6;
        test_name      = "reset";
        m_state        = 0;
        m_args         = 0;
        {sh_off_x, sh_off_y, sh_dest_stride, sh_src_stride} = '0;
        {sh_clip_x1, sh_clip_y1, sh_clip_x2, sh_clip_y2} = '0;
        {sh_dest_addr, sh_src_addr} = '0;
        sh_transp = transparent_off;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);

        begin_test("reset_defaults");
        check_value("cmd_ready", 1, cmd_ready);
        check_value("start", 0, start);
        run_test();

        begin_test("setup_draw_rect");
        add_command(4, 1'b1);
        repeat (10) add_command(1, rand_below(2) == 1);
        run_test();

        begin_test("copy_rect");
        add_command(4, 1'b1);
        repeat (10) add_command(2, rand_below(2) == 1);
        run_test();

        begin_test("privilege_unknown");
        repeat (4) begin
            add_command(4, 1'b0);
            repeat (3) begin
                pick = rand_below(3);
                add_command((pick == 2) ? 5 : pick, rand_below(2) == 1);
            end
        end
        run_test();

        begin_test("transparency");
        repeat (6) begin
            add_command(3, rand_below(2) == 1);
            add_command(0, 1'b0);
        end
        run_test();

        begin_test("back_pressure");
        ack_span    = 12;
        busy_span   = 24;
        full_before = full_cycles;
        repeat (60) add_command(rand_below(6), rand_below(4) != 0);
        run_test();
        if (full_cycles == full_before) begin
            errors++;
            $display("back_pressure: FIFO never filled, cmd_ready stayed high");
        end

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: blit_command_parser.f
rtl/blit_pkg.sv
rtl/blit_cmd_fifo.sv
rtl/blit_setup_regs.sv
rtl/blit_cmd_decoder.sv
rtl/blit_command_parser.sv
verif/blit_command_parser_asserts.sv
verif/blit_command_parser_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the blit command parser testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module blit_command_parser_tb \
    -f blit_command_parser.f \
    -o blit_sim

./obj_dir/blit_sim > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
